/* src/rcfg_pkg.sv */
/*
  Reconfiguration side definitions for the PCS reconfiguration engine.
  Holds the one-hot mode encoding, the table geometry and the layout of
  one table entry. Import into any block that walks or decodes the table.
*/

package rcfg_pkg;

  // one-hot mode word, one bit per PCS mode
  localparam int pcs_mode_w    = 6;
  localparam int mode_an       = 0;
  localparam int mode_lt       = 1;
  localparam int mode_teng     = 2;
  localparam int mode_gige     = 3;
  localparam int mode_xaui     = 4;
  localparam int mode_fec_teng = 5;

  // table geometry
  localparam int num_slots     = 5;
  localparam int rows_per_slot = 8;
  localparam int row_idx_w     = 3;
  localparam int slot_idx_w    = 3;

  // entry fields, address on top, data at the bottom
  localparam int entry_addr_w = 10;
  localparam int entry_mask_w = 8;
  localparam int entry_data_w = 8;
  localparam int entry_w      = entry_addr_w + entry_mask_w + entry_data_w;

  typedef struct packed {
    logic [entry_addr_w-1:0] addr;
    logic [entry_mask_w-1:0] mask;
    logic [entry_data_w-1:0] data;
  } rcfg_entry_t;

  // list terminator, all fields ones
  localparam rcfg_entry_t entry_end = '1;

  localparam string table_file = "src/rcfg_table.hex";

endpackage

/* src/dprio_pkg.sv */
/*
  DPRIO bus side definitions: register port widths and the status word
  returned on the done channel after a reconfiguration run.
*/

package dprio_pkg;

  localparam int dprio_addr_w = 10;
  localparam int dprio_data_w = 8;

  // enough for seven writes per run
  localparam int count_w = 4;

  // error flag on top, write count below
  typedef struct packed {
    logic               error;
    logic [count_w-1:0] count;
  } done_status_t;

endpackage

/* src/rmw_if.sv */
/*
  Command channel between the table sequencer and the read-modify-write
  engine. One table entry per transfer, cmd_done pulses once per entry.
*/

`timescale 1ns/1ps

interface rmw_if import rcfg_pkg::*; ();

  logic        cmd_valid;
  logic        cmd_ready;
  rcfg_entry_t cmd;
  // one cycle per finished entry
  logic        cmd_done;

  modport seq (
    output cmd_valid,
    output cmd,
    input  cmd_ready,
    input  cmd_done
  );

  modport eng (
    input  cmd_valid,
    input  cmd,
    output cmd_ready,
    output cmd_done
  );

endinterface

/* src/dprio_if.sv */
/*
  DPRIO master bus bundle. The engine drives it through the master
  modport; the top level only takes it out to plain ports.
*/

`timescale 1ns/1ps

interface dprio_if import dprio_pkg::*; ();

  logic [dprio_addr_w-1:0] address;
  logic                    read;
  logic                    write;
  logic [dprio_data_w-1:0] writedata;
  logic [dprio_data_w-1:0] readdata;
  // stretches the current access while high
  logic                    waitrequest;

  modport master (
    output address,
    output read,
    output write,
    output writedata,
    input  readdata,
    input  waitrequest
  );

  modport port (
    input  address,
    input  read,
    input  write,
    input  writedata,
    output readdata,
    output waitrequest
  );

endinterface

/* src/rcfg_data_table.sv */
/*
  Constant PCS reconfiguration table. Rows are loaded once from the data
  file, eight per mode slot. The one-hot mode picks the slot, the row
  index picks the entry; lookup is purely combinational.
*/

`timescale 1ns/1ps

module rcfg_data_table import rcfg_pkg::*; (
  input  logic [row_idx_w-1:0]  row,
  input  logic [pcs_mode_w-1:0] mode,
  output rcfg_entry_t           entry,
  output logic                  hit
);

  logic [entry_w-1:0]              rom [num_slots*rows_per_slot];
  logic [slot_idx_w-1:0]           slot;
  logic [slot_idx_w+row_idx_w-1:0] rom_idx;

  initial begin
    $readmemh(table_file, rom);
  end

  // ====================
  // mode to slot
  // ====================
  always_comb begin
    slot = '0;
    hit  = 1'b0;
    if ($onehot(mode)) begin
      hit = 1'b1;
      if (mode[mode_an]) begin
        slot = slot_idx_w'(0);
      end else if (mode[mode_lt]) begin
        slot = slot_idx_w'(1);
      end else if (mode[mode_teng]) begin
        slot = slot_idx_w'(2);
      end else if (mode[mode_gige]) begin
        slot = slot_idx_w'(3);
      end else if (mode[mode_fec_teng]) begin
        slot = slot_idx_w'(4);
      end else if (mode[mode_xaui]) begin
        // xaui has no table
        hit = 1'b0;
      end
    end
  end

  // slot selects a block of eight rows
  assign rom_idx = {slot, row};
  assign entry   = rcfg_entry_t'(rom[rom_idx]);

endmodule

/* src/rcfg_sequencer.sv */
/*
  Walks the entry list of the requested PCS mode and feeds the entries to
  the read-modify-write engine, keeping one entry staged ahead. Stops at
  the terminator or after the last row and reports the write count.
*/

`timescale 1ns/1ps

module rcfg_sequencer import rcfg_pkg::*, dprio_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  logic [pcs_mode_w-1:0] req_mode,
  output logic                  req_ready,
  output logic                  done_valid,
  output done_status_t          done_status,
  input  logic                  done_ready,
  output logic [row_idx_w-1:0]  tbl_row,
  output logic [pcs_mode_w-1:0] tbl_mode,
  input  rcfg_entry_t           tbl_entry,
  input  logic                  tbl_hit,
  rmw_if.seq                    rmw
);

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_run,
    st_drain,
    st_done
  } seq_state_t;

  seq_state_t            state;
  logic [pcs_mode_w-1:0] mode_q;
  logic [row_idx_w-1:0]  row_q;
  logic                  row_last_q;
  rcfg_entry_t           cmd_q;
  logic                  cmd_valid_q;
  logic [count_w-1:0]    count_q;
  logic                  error_q;
  logic                  handoff;
  logic                  stage_stop;

  // engine takes the staged entry
  assign handoff    = cmd_valid_q & rmw.cmd_ready;
  // nothing left to stage behind the current one
  assign stage_stop = row_last_q | (tbl_entry == entry_end);

  assign req_ready     = (state == st_idle);
  assign done_valid    = (state == st_done);
  assign done_status   = '{error: error_q, count: count_q};
  assign tbl_row       = row_q;
  assign tbl_mode      = mode_q;
  assign rmw.cmd_valid = cmd_valid_q;
  assign rmw.cmd       = cmd_q;

  // ====================
  // control FSM
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      row_q       <= '0;
      row_last_q  <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) begin
            row_q      <= '0;
            row_last_q <= 1'b0;
            state      <= st_fetch;
          end
        end
        st_fetch: begin
          // miss or empty list, report right away
          if (!tbl_hit || tbl_entry == entry_end) begin
            state <= st_done;
          end else begin
            cmd_valid_q <= 1'b1;
            row_q       <= row_q + 1'b1;
            state       <= st_run;
          end
        end
        st_run: begin
          if (handoff) begin
            if (stage_stop) begin
              cmd_valid_q <= 1'b0;
              state       <= st_drain;
            end else begin
              row_q      <= row_q + 1'b1;
              row_last_q <= (row_q == row_idx_w'(rows_per_slot - 1));
            end
          end
        end
        st_drain: begin
          // last entry still in the engine
          if (rmw.cmd_done) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (done_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ====================
  // mode, staged entry, status
  // ====================
  always_ff @(posedge clk) begin
    if (state == st_idle && req_valid) begin
      mode_q  <= req_mode;
      count_q <= '0;
      error_q <= 1'b0;
    end
    if (state == st_fetch) begin
      error_q <= ~tbl_hit;
      cmd_q   <= tbl_entry;
    end
    if (state == st_run && handoff && !stage_stop) begin
      cmd_q <= tbl_entry;
    end
    if (rmw.cmd_done) begin
      count_q <= count_q + 1'b1;
    end
  end

endmodule

/* src/dprio_rmw.sv */
/*
  Masked read-modify-write engine on the DPRIO master port. Per command it
  reads the register, merges the masked data bits in, writes the result
  back and pulses cmd_done. Accesses hold as long as waitrequest is high.
*/

`timescale 1ns/1ps

module dprio_rmw import rcfg_pkg::*, dprio_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  rmw_if.eng     rmw,
  dprio_if.master bus
);

  typedef enum logic [1:0] {
    eng_idle,
    eng_read,
    eng_write
  } eng_state_t;

  eng_state_t              state;
  rcfg_entry_t             cmd_q;
  logic [dprio_data_w-1:0] merged;
  logic [dprio_data_w-1:0] merge_q;
  logic                    done_q;

  // keep unmasked read bits, take masked bits from the entry
  assign merged = (bus.readdata & ~cmd_q.mask) | (cmd_q.data & cmd_q.mask);

  assign rmw.cmd_ready = (state == eng_idle);
  assign rmw.cmd_done  = done_q;

  // strobes follow the state, address from the held command
  assign bus.read      = (state == eng_read);
  assign bus.write     = (state == eng_write);
  assign bus.address   = dprio_addr_w'(cmd_q.addr);
  assign bus.writedata = merge_q;

  // ====================
  // access sequencing
  // ====================
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= eng_idle;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        eng_idle: begin
          if (rmw.cmd_valid) begin
            state <= eng_read;
          end
        end
        eng_read: begin
          if (!bus.waitrequest) begin
            state <= eng_write;
          end
        end
        eng_write: begin
          if (!bus.waitrequest) begin
            state  <= eng_idle;
            done_q <= 1'b1;
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

  // command and merged value
  always_ff @(posedge clk) begin
    if (state == eng_idle && rmw.cmd_valid) begin
      cmd_q <= rmw.cmd;
    end
    // read data valid in the accepting cycle
    if (state == eng_read && !bus.waitrequest) begin
      merge_q <= merged;
    end
  end

endmodule

/* src/pcs_reconfig_top.sv */
/*
  PCS reconfiguration engine top level. Ties the sequencer, the constant
  table and the DPRIO read-modify-write engine together and brings the
  request, done and DPRIO channels out as plain ports.
*/

`timescale 1ns/1ps

module pcs_reconfig_top import rcfg_pkg::*, dprio_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  // request channel
  input  logic                    req_valid,
  input  logic [pcs_mode_w-1:0]   req_mode,
  output logic                    req_ready,
  // done channel
  output logic                    done_valid,
  output logic                    done_error,
  output logic [count_w-1:0]      done_count,
  input  logic                    done_ready,
  // DPRIO master
  output logic [dprio_addr_w-1:0] dprio_address,
  output logic                    dprio_read,
  output logic                    dprio_write,
  output logic [dprio_data_w-1:0] dprio_writedata,
  input  logic [dprio_data_w-1:0] dprio_readdata,
  input  logic                    dprio_waitrequest
);

  logic [row_idx_w-1:0]  tbl_row;
  logic [pcs_mode_w-1:0] tbl_mode;
  rcfg_entry_t           tbl_entry;
  logic                  tbl_hit;
  done_status_t          done_status;

  rmw_if   rmw ();
  dprio_if dprio_bus ();

  rcfg_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_mode    (req_mode),
    .req_ready   (req_ready),
    .done_valid  (done_valid),
    .done_status (done_status),
    .done_ready  (done_ready),
    .tbl_row     (tbl_row),
    .tbl_mode    (tbl_mode),
    .tbl_entry   (tbl_entry),
    .tbl_hit     (tbl_hit),
    .rmw         (rmw.seq)
  );

  rcfg_data_table u_table (
    .row   (tbl_row),
    .mode  (tbl_mode),
    .entry (tbl_entry),
    .hit   (tbl_hit)
  );

  dprio_rmw u_rmw (
    .clk (clk),
    .rst (rst),
    .rmw (rmw.eng),
    .bus (dprio_bus.master)
  );

  assign done_error = done_status.error;
  assign done_count = done_status.count;

  // ====================
  // DPRIO port side
  // ====================
  assign dprio_address         = dprio_bus.address;
  assign dprio_read            = dprio_bus.read;
  assign dprio_write           = dprio_bus.write;
  assign dprio_writedata       = dprio_bus.writedata;
  assign dprio_bus.readdata    = dprio_readdata;
  assign dprio_bus.waitrequest = dprio_waitrequest;

endmodule

/* testbench/pcs_reconfig_chk.sv */
/*
  Protocol checker for the PCS reconfiguration top level, attached by bind.
  Watches DPRIO strobe exclusivity and hold under waitrequest, done channel
  hold under back-pressure and bus silence while the engine is idle.
*/

`timescale 1ns/1ps

module pcs_reconfig_chk import dprio_pkg::*; (
  input logic                    clk,
  input logic                    rst,
  input logic                    req_ready,
  input logic                    done_valid,
  input logic                    done_error,
  input logic [count_w-1:0]      done_count,
  input logic                    done_ready,
  input logic [dprio_addr_w-1:0] dprio_address,
  input logic                    dprio_read,
  input logic                    dprio_write,
  input logic [dprio_data_w-1:0] dprio_writedata,
  input logic                    dprio_waitrequest
);

  // assertion failures so far
  int chk_errors = 0;

  strobe_excl: assert property (@(posedge clk) disable iff (rst)
    !(dprio_read && dprio_write))
    else begin
      $error("DPRIO read and write strobes high in the same cycle");
      chk_errors++;
    end

  // held access keeps strobe, address and data
  access_hold: assert property (@(posedge clk) disable iff (rst)
    (dprio_read || dprio_write) && dprio_waitrequest |=>
      $stable(dprio_read) && $stable(dprio_write) &&
      $stable(dprio_address) && $stable(dprio_writedata))
    else begin
      $error("DPRIO access changed while waitrequest was high");
      chk_errors++;
    end

  done_hold: assert property (@(posedge clk) disable iff (rst)
    done_valid && !done_ready |=>
      done_valid && $stable(done_error) && $stable(done_count))
    else begin
      $error("done status changed before done_ready");
      chk_errors++;
    end

  idle_quiet: assert property (@(posedge clk) disable iff (rst)
    req_ready |-> !(dprio_read || dprio_write))
    else begin
      $error("DPRIO strobe high while a request can be accepted");
      chk_errors++;
    end

endmodule

bind pcs_reconfig_top pcs_reconfig_chk u_chk (
  .clk               (clk),
  .rst               (rst),
  .req_ready         (req_ready),
  .done_valid        (done_valid),
  .done_error        (done_error),
  .done_count        (done_count),
  .done_ready        (done_ready),
  .dprio_address     (dprio_address),
  .dprio_read        (dprio_read),
  .dprio_write       (dprio_write),
  .dprio_writedata   (dprio_writedata),
  .dprio_waitrequest (dprio_waitrequest)
);

/* testbench/tb_pcs_reconfig.sv */
/*
  Testbench for the PCS reconfiguration top level. Models the transceiver
  DPRIO register file, predicts each run from the table file and runs
  directed tests on modes, masking, stalls, bad requests and back-pressure.
*/

`timescale 1ns/1ps

module tb_pcs_reconfig import rcfg_pkg::*, dprio_pkg::*; ();

  localparam int clk_half   = 50;
  localparam int num_rows   = num_slots * rows_per_slot;
  localparam int reg_count  = 1 << dprio_addr_w;
  // 22 requests, each far below 180 cycles even with stalls
  localparam int max_cycles = 4000;

  logic                    clk;
  logic                    rst;
  logic                    req_valid;
  logic [pcs_mode_w-1:0]   req_mode;
  logic                    req_ready;
  logic                    done_valid;
  logic                    done_error;
  logic [count_w-1:0]      done_count;
  logic                    done_ready;
  logic [dprio_addr_w-1:0] dprio_address;
  logic                    dprio_read;
  logic                    dprio_write;
  logic [dprio_data_w-1:0] dprio_writedata;
  logic [dprio_data_w-1:0] dprio_readdata;
  logic                    dprio_waitrequest;

  logic [entry_w-1:0] tbl_rows   [num_rows];
  logic [7:0]         regs       [reg_count];
  logic [7:0]         init_img   [reg_count];
  logic [7:0]         exp_img    [reg_count];
  logic [7:0]         touch_mask [reg_count];
  int                 tabled_modes [num_slots];
  logic               preload_req;
  logic               stall_en;
  int                 rd_count;
  int                 wr_count;
  int                 errors;
  int                 cycle_count;

  pcs_reconfig_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_half) clk = ~clk;
  end

  // ====================
  // DPRIO register model
  // ====================
  assign dprio_readdata = regs[dprio_address];

  initial begin : dprio_model
    for (int a = 0; a < reg_count; a++) regs[a] <= 8'(a) ^ 8'(a >> 2);
    rd_count <= 0;
    wr_count <= 0;
    forever begin
      @(posedge clk);
      if (preload_req) begin
        for (int a = 0; a < reg_count; a++) regs[a] <= init_img[a];
      end else if (dprio_write && !dprio_waitrequest) begin
        regs[dprio_address] <= dprio_writedata;
        wr_count <= wr_count + 1;
      end
      if (dprio_read && !dprio_waitrequest) rd_count <= rd_count + 1;
    end
  end

  // waitrequest high about two cycles in three while stalls are on
  initial begin : wait_gen
    dprio_waitrequest = 1'b0;
    forever begin
      @(negedge clk);
      dprio_waitrequest = stall_en && ($urandom_range(0, 2) != 0);
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run still busy after %0d clock cycles", max_cycles);
    $display("Test failures found");
    $finish;
  end

  // ====================
  // helpers
  // ====================
  function automatic int slot_of(int mode_bit);
    case (mode_bit)
      mode_an:       return 0;
      mode_lt:       return 1;
      mode_teng:     return 2;
      mode_gige:     return 3;
      mode_fec_teng: return 4;
      default:       return -1;
    endcase
  endfunction

  task automatic check_value(string test, string what, int exp_val, int act_val);
    assert (act_val == exp_val) else begin
      $display("[FAIL] %s: %s expected %0d, got %0d", test, what, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic reload_image();
    preload_req = 1'b1;
    @(negedge clk);
    preload_req = 1'b0;
  endtask

  task automatic preload_random();
    for (int a = 0; a < reg_count; a++) init_img[a] = 8'($urandom);
    reload_image();
  endtask

  // apply the slot's rows in order up to the all-ones terminator
  task automatic predict_run(int slot, output int rows);
    logic [entry_w-1:0] e;
    rows = 0;
    for (int a = 0; a < reg_count; a++) begin
      exp_img[a]    = init_img[a];
      touch_mask[a] = 8'h00;
    end
    for (int r = 0; r < rows_per_slot; r++) begin
      e = tbl_rows[slot * rows_per_slot + r];
      if (&e) break;
      exp_img[e[25:16]]    = (exp_img[e[25:16]] & ~e[15:8]) | (e[7:0] & e[15:8]);
      touch_mask[e[25:16]] = touch_mask[e[25:16]] | e[15:8];
      rows++;
    end
  endtask

  task automatic send_request(logic [pcs_mode_w-1:0] mode);
    req_valid = 1'b1;
    req_mode  = mode;
    while (!req_ready) @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic collect_done(output logic err, output logic [count_w-1:0] cnt);
    while (!done_valid) @(negedge clk);
    err        = done_error;
    cnt        = done_count;
    done_ready = 1'b1;
    @(negedge clk);
    done_ready = 1'b0;
  endtask

  task automatic compare_image(string test);
    for (int a = 0; a < reg_count; a++) begin
      assert (regs[a] == exp_img[a]) else begin
        $display("[FAIL] %s: register %03h expected %02h, got %02h",
                 test, a, exp_img[a], regs[a]);
        errors++;
      end
    end
  endtask

  task automatic run_mode(string test, int mode_bit, logic stall);
    logic               err;
    logic [count_w-1:0] cnt;
    int                 rows;
    int                 wr0;
    predict_run(slot_of(mode_bit), rows);
    stall_en = stall;
    wr0      = wr_count;
    send_request(pcs_mode_w'(1 << mode_bit));
    collect_done(err, cnt);
    stall_en = 1'b0;
    check_value(test, "done_error", 0, int'(err));
    check_value(test, "done_count", rows, int'(cnt));
    check_value(test, "bus writes", rows, wr_count - wr0);
    compare_image(test);
  endtask

  // ====================
  // tests
  // ====================
  task automatic test_all_modes();
    for (int i = 0; i < num_slots; i++) begin
      preload_random();
      run_mode($sformatf("all_modes bit %0d", tabled_modes[i]), tabled_modes[i], 1'b0);
    end
  endtask

  task automatic test_masked_merge();
    logic [7:0] keep;
    for (int i = 1; i < num_slots; i += 2) begin
      preload_random();
      run_mode("masked_merge", tabled_modes[i], 1'b0);
      for (int a = 0; a < reg_count; a++) begin
        keep = ~touch_mask[a];
        assert ((regs[a] & keep) == (init_img[a] & keep)) else begin
          $display("[FAIL] masked_merge: register %03h expected %02h, got %02h",
                   a, init_img[a] & keep, regs[a] & keep);
          errors++;
        end
      end
    end
  endtask

  // each preload run clean and then with stalls
  task automatic test_stalls();
    for (int i = 0; i < num_slots; i++) begin
      preload_random();
      run_mode("stall_reference", tabled_modes[i], 1'b0);
      reload_image();
      run_mode($sformatf("stalls bit %0d", tabled_modes[i]), tabled_modes[i], 1'b1);
    end
  endtask

  task automatic test_unsupported();
    logic [pcs_mode_w-1:0] bad [3];
    logic                  err;
    logic [count_w-1:0]    cnt;
    int                    rd0;
    int                    wr0;
    bad[0] = pcs_mode_w'(1 << mode_xaui);
    bad[1] = '0;
    bad[2] = pcs_mode_w'((1 << mode_an) | (1 << mode_gige));
    for (int i = 0; i < 3; i++) begin
      rd0 = rd_count;
      wr0 = wr_count;
      send_request(bad[i]);
      collect_done(err, cnt);
      check_value("unsupported", "done_error", 1, int'(err));
      check_value("unsupported", "done_count", 0, int'(cnt));
      check_value("unsupported", "bus reads", 0, rd_count - rd0);
      check_value("unsupported", "bus writes", 0, wr_count - wr0);
    end
  endtask

  task automatic test_done_backpressure();
    logic               err;
    logic               err_hold;
    logic [count_w-1:0] cnt;
    logic [count_w-1:0] cnt_hold;
    int                 rows;
    preload_random();
    predict_run(slot_of(mode_an), rows);
    send_request(pcs_mode_w'(1 << mode_an));
    while (!done_valid) @(negedge clk);
    err_hold = done_error;
    cnt_hold = done_count;
    repeat (20) begin
      @(negedge clk);
      check_value("backpressure", "done_valid", 1, int'(done_valid));
      check_value("backpressure", "done_error", int'(err_hold), int'(done_error));
      check_value("backpressure", "done_count", int'(cnt_hold), int'(done_count));
      check_value("backpressure", "req_ready", 0, int'(req_ready));
    end
    collect_done(err, cnt);
    check_value("backpressure", "done_error", 0, int'(err));
    check_value("backpressure", "done_count", rows, int'(cnt));
    compare_image("backpressure");
    check_value("backpressure", "req_ready after done", 1, int'(req_ready));
    preload_random();
    run_mode("backpressure_next", mode_teng, 1'b0);
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin : main_seq
    void'($urandom(26843));
    errors      = 0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_mode    = '0;
    done_ready  = 1'b0;
    preload_req = 1'b0;
    stall_en    = 1'b0;
    tabled_modes = '{mode_an, mode_lt, mode_teng, mode_gige, mode_fec_teng};
    $readmemh(table_file, tbl_rows);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_all_modes();
    test_masked_merge();
    test_stalls();
    test_unsupported();
    test_done_backpressure();

    errors = errors + UUT.u_chk.chk_errors;
    $display("Run complete: %0d errors after %0d cycles", errors, cycle_count);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* src/rcfg_table.hex */
// PCS reconfiguration table, eight rows per mode slot, 26-bit words
// columns: addr (3 hex digits) mask (2) data (2); 3FFFFFF ends a list
// slot 0, auto-negotiation
0800F05
081C040
0820301
3FFFFFF
3FFFFFF
3FFFFFF
3FFFFFF
3FFFFFF
// slot 1, link training, 0C0 written twice
0C0FF3C
0C10101
0C2F0A0
0C00F09
3FFFFFF
3FFFFFF
3FFFFFF
3FFFFFF
// slot 2, 10GBASE-R, full list
1003F15
1018080
1020702
1031010
104FFC3
105E060
1014000
3FFFFFF
// slot 3, GigE
2000F0A
2013C14
202FF55
203C381
2000F01
3FFFFFF
3FFFFFF
3FFFFFF
// slot 4, 10G with FEC
1003F2A
1021C0C
2A0FF11
2A10F0F
2A2F000
2A3FF7E
2A03300
3FFFFFF

/* filelist.f */
src/rcfg_pkg.sv
src/dprio_pkg.sv
src/rmw_if.sv
src/dprio_if.sv
src/rcfg_data_table.sv
src/rcfg_sequencer.sv
src/dprio_rmw.sv
src/pcs_reconfig_top.sv
testbench/pcs_reconfig_chk.sv
testbench/tb_pcs_reconfig.sv

/* run.sh */
#!/bin/sh
# Build and run the PCS reconfiguration testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pcs_reconfig \
  -f filelist.f \
  -o sim_pcs_reconfig

./obj_dir/sim_pcs_reconfig +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi
echo "simulation passed"
